// ==== jpeg_backend.f ====
verilog/jpeg_backend_pkg.sv
verilog/bit_packer.sv
verilog/frame_flush_control.sv
verilog/word_byte_fifo.sv
verilog/byte_stuffer.sv
verilog/jpeg_backend.sv
verification/tb_jpeg_backend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the JPEG back end testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module tb_jpeg_backend \
    --Mdir "$BUILD_DIR" \
    -f jpeg_backend.f

"./$BUILD_DIR/Vtb_jpeg_backend" 2>&1 | tee "$LOG_FILE"

if grep -qx "test passed" "$LOG_FILE"; then
    echo "simulation result: PASS"
    exit 0
else
    echo "simulation result: FAIL (see $LOG_FILE)"
    exit 1
fi

// ==== verification/tb_jpeg_backend.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the JPEG output back end
// sends two frames of random codewords, rebuilds the expected stream from
// a bit queue and checks the unstuffed bytes, the stuffing and the
// frame-active flag
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_jpeg_backend
    import jpeg_backend_pkg::*;
();

    localparam int CLOCK_PERIOD        = 4;
    localparam int RESET_CYCLES        = 10;
    localparam int FRAMES              = 2;
    localparam int CODEWORDS_PER_FRAME = 40;
    localparam int LATE_CODEWORDS      = 4;
    localparam int MIN_GAP             = 8;
    localparam int GAP_SPREAD          = 5;
    localparam int DONE_HOLD           = 400;

    // longest possible stimulus in clock cycles
    localparam int STIM_CYCLES = RESET_CYCLES
        + FRAMES * (CODEWORDS_PER_FRAME * (MIN_GAP + GAP_SPREAD + 1) + MIN_GAP + DONE_HOLD + 2);
    localparam int WATCHDOG_CYCLES = STIM_CYCLES * 3 / 2 + 2 * DRAIN_CYCLES;

    logic         clock;
    logic         nreset;
    logic         codeword_valid;
    codeword_t    codeword;
    code_len_t    codeword_len;
    logic         frame_done;
    logic         byte_valid;
    stream_byte_t stream_byte;
    logic         frame_active;

    integer       seed;
    bit           expected_bits[$];
    int           bits_this_frame;
    int           total_bits;
    int           done_cycles;
    int           active_wait;
    bit           stuff_pending;
    stream_byte_t expected_byte;

    jpeg_backend dut (
        .clock            (clock),
        .nreset           (nreset),
        .codeword_valid_i (codeword_valid),
        .codeword_i       (codeword),
        .codeword_len_i   (codeword_len),
        .frame_done_i     (frame_done),
        .byte_valid_o     (byte_valid),
        .byte_o           (stream_byte),
        .frame_active_o   (frame_active)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // failure reporting
    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic flag_mismatch(input string name, input logic expected,
                                 input logic actual);
        $display("[FAIL] time=%0t signal=%s expected=%0b actual=%0b",
                 $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic byte_mismatch(input string name, input stream_byte_t expected,
                                 input stream_byte_t actual);
        $display("[FAIL] time=%0t signal=%s expected=%02h actual=%02h",
                 $time, name, expected, actual);
        stop_with_failure();
    endtask

    task automatic abort_run(input string reason);
        $display("error at time %0t: %s", $time, reason);
        stop_with_failure();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    function automatic int pick_in_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic drive_slot();
        @(posedge clock);
        #0.5;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) drive_slot();
    endtask

    // the reference stream holds codeword bits MSB first
    task automatic queue_bits(input codeword_t value, input int len);
        for (int i = len - 1; i >= 0; i--) begin
            expected_bits.push_back(value[i]);
        end
    endtask

    task automatic pop_expected_byte(output stream_byte_t value);
        for (int i = BYTE_WIDTH - 1; i >= 0; i--) begin
            value[i] = expected_bits.pop_front();
        end
    endtask

    task automatic send_codeword(input codeword_t value, input int len,
                                 input bit counted, input int gap);
        drive_slot();
        codeword_valid = 1'b1;
        codeword = value;
        codeword_len = code_len_t'(len);
        if (counted) begin
            queue_bits(value, len);
            bits_this_frame += len;
            total_bits += len;
        end
        drive_slot();
        codeword_valid = 1'b0;
        codeword = '0;
        codeword_len = '0;
        wait_cycles(gap - 1);
    endtask

    task automatic send_frame();
        codeword_t value;
        int        len;
        for (int n = 0; n < CODEWORDS_PER_FRAME; n++) begin
            value = $random(seed);
            len = pick_in_range(1, WORD_WIDTH);
            if (n % 4 == 3) begin
                // sixteen ones in a row always cover one whole aligned byte
                value = '1;
                len = pick_in_range(16, WORD_WIDTH);
            end
            send_codeword(value, len, 1'b1, MIN_GAP + pick_in_range(0, GAP_SPREAD - 1));
        end
        wait_cycles(MIN_GAP);
    endtask

    task automatic end_frame();
        int pad_len;
        // a frame that ends on a word boundary still gets a whole word of ones
        pad_len = WORD_WIDTH - (bits_this_frame % WORD_WIDTH);
        drive_slot();
        frame_done = 1'b1;
        queue_bits('1, pad_len);

        // late codewords hit the CLEAR state and must never show up
        wait_cycles(10);
        for (int i = 0; i < LATE_CODEWORDS; i++) begin
            send_codeword($random(seed), pick_in_range(1, WORD_WIDTH), 1'b0, MIN_GAP);
        end
        wait_cycles(DONE_HOLD - 10 - LATE_CODEWORDS * (MIN_GAP + 1));
        frame_done = 1'b0;
        bits_this_frame = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stream and flag checks, sampled away from the rising edge
    always @(negedge clock) begin
        if (!nreset) begin
            if (total_bits < WORD_WIDTH) begin
                assert (!byte_valid) else flag_mismatch("byte_valid_o", 1'b0, byte_valid);
                assert (!frame_active)
                    else flag_mismatch("frame_active_o", 1'b0, frame_active);
            end

            if (stuff_pending) begin
                assert (byte_valid) else flag_mismatch("byte_valid_o", 1'b1, byte_valid);
                assert (stream_byte == 8'h00)
                    else byte_mismatch("byte_o", 8'h00, stream_byte);
                stuff_pending = 1'b0;
            end else if (byte_valid) begin
                assert (expected_bits.size() >= BYTE_WIDTH)
                    else abort_run("byte_o carried a byte that no codeword accounts for");
                pop_expected_byte(expected_byte);
                assert (stream_byte == expected_byte)
                    else byte_mismatch("byte_o", expected_byte, stream_byte);
                stuff_pending = (stream_byte == 8'hff);
            end

            if (frame_done) begin
                done_cycles++;
            end else begin
                done_cycles = 0;
            end
            if (bits_this_frame < WORD_WIDTH) begin
                active_wait = 0;
            end else if (active_wait < 3) begin
                active_wait++;
            end

            // done_cycles runs one ahead of the posedges seen by the drain timer
            if (frame_done && bits_this_frame >= WORD_WIDTH) begin
                if (done_cycles <= DRAIN_CYCLES + 1) begin
                    assert (frame_active)
                        else flag_mismatch("frame_active_o", 1'b1, frame_active);
                end else if (done_cycles >= DRAIN_CYCLES + 2) begin
                    assert (!frame_active)
                        else flag_mismatch("frame_active_o", 1'b0, frame_active);
                end
            end else if (!frame_done && bits_this_frame < WORD_WIDTH) begin
                assert (!frame_active)
                    else flag_mismatch("frame_active_o", 1'b0, frame_active);
            end else if (!frame_done && active_wait >= 3) begin
                assert (frame_active)
                    else flag_mismatch("frame_active_o", 1'b1, frame_active);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        abort_run("the watchdog expired and the run timed out");
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        seed = 32'ha807;
        clock = 1'b0;
        nreset = 1'b1;
        codeword_valid = 1'b0;
        codeword = '0;
        codeword_len = '0;
        frame_done = 1'b0;
        bits_this_frame = 0;
        total_bits = 0;
        done_cycles = 0;
        active_wait = 0;
        stuff_pending = 1'b0;

        repeat (RESET_CYCLES) @(posedge clock);
        #0.5;
        nreset = 1'b0;
        wait_cycles(MIN_GAP);

        for (int f = 0; f < FRAMES; f++) begin
            send_frame();
            end_frame();
            wait_cycles(MIN_GAP);
        end

        if (expected_bits.size() == 0 && !stuff_pending) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("the byte stream stopped with %0d expected bits not seen",
                                expected_bits.size()));
        end
    end

endmodule

// ==== verilog/jpeg_backend.sv ====
////////////////////////////////////////////////////////////////////////////
// JPEG output back end
// turns entropy codewords into a stuffed JPEG byte stream with a
// frame-active flag that covers the pipeline drain
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module jpeg_backend
    import jpeg_backend_pkg::*;
(
    input  logic         clock,
    input  logic         nreset,

    input  logic         codeword_valid_i,
    input  codeword_t    codeword_i,
    input  code_len_t    codeword_len_i,
    input  logic         frame_done_i,

    output logic         byte_valid_o,
    output stream_byte_t byte_o,
    output logic         frame_active_o
);

    logic         pack_valid;
    codeword_t    pack_data;
    code_len_t    pack_len;
    logic         pack_clear;

    logic         word_valid;
    packed_word_t word_data;

    logic         fifo_byte_valid;
    stream_byte_t fifo_byte;
    logic         stuffer_ready;

    frame_flush_control u_flush (
        .clock            (clock),
        .nreset           (nreset),
        .frame_done_i     (frame_done_i),
        .codeword_valid_i (codeword_valid_i),
        .codeword_i       (codeword_i),
        .codeword_len_i   (codeword_len_i),
        .word_valid_i     (word_valid),
        .pack_valid_o     (pack_valid),
        .pack_data_o      (pack_data),
        .pack_len_o       (pack_len),
        .pack_clear_o     (pack_clear),
        .frame_active_o   (frame_active_o)
    );

    bit_packer u_packer (
        .clock        (clock),
        .nreset       (nreset),
        .valid_i      (pack_valid),
        .data_i       (pack_data),
        .len_i        (pack_len),
        .clear_i      (pack_clear),
        .word_valid_o (word_valid),
        .word_o       (word_data)
    );

    word_byte_fifo u_fifo (
        .clock        (clock),
        .nreset       (nreset),
        .word_valid_i (word_valid),
        .word_i       (word_data),
        .ready_i      (stuffer_ready),
        .byte_valid_o (fifo_byte_valid),
        .byte_o       (fifo_byte)
    );

    byte_stuffer u_stuffer (
        .clock   (clock),
        .nreset  (nreset),
        .valid_i (fifo_byte_valid),
        .byte_i  (fifo_byte),
        .ready_o (stuffer_ready),
        .valid_o (byte_valid_o),
        .byte_o  (byte_o)
    );

endmodule

// ==== verilog/byte_stuffer.sv ====
////////////////////////////////////////////////////////////////////////////
// JPEG byte stuffer
// registers the byte stream and follows every FF with an inserted 00,
// stalling the byte FIFO for the cycle of the insertion
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module byte_stuffer
    import jpeg_backend_pkg::*;
(
    input  logic         clock,
    input  logic         nreset,

    input  logic         valid_i,
    input  stream_byte_t byte_i,
    output logic         ready_o,

    output logic         valid_o,
    output stream_byte_t byte_o
);

    logic stuff_now;

    // an FF on the output means the next output slot belongs to the 00
    assign stuff_now = valid_o && (byte_o == stream_byte_t'(8'hff));
    assign ready_o = !stuff_now;

    always_ff @(posedge clock) begin
        if (nreset) begin
            valid_o <= 1'b0;
        end else if (stuff_now) begin
            valid_o <= 1'b1;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (stuff_now) begin
            byte_o <= '0;
        end else if (valid_i) begin
            byte_o <= byte_i;
        end
    end

    // the 00 follows the FF while the byte waiting at the input is held back
    a_ff_followed_by_zero: assert property (
        @(posedge clock) disable iff (nreset)
        (stuff_now && valid_i)
            |=> valid_o && (byte_o == stream_byte_t'(8'h00))
                && valid_i && $stable(byte_i)
    );

endmodule

// ==== verilog/word_byte_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// word to byte FIFO
// buffers packed words and hands them to the byte stuffer one byte per
// handshake, most significant byte first
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module word_byte_fifo
    import jpeg_backend_pkg::*;
(
    input  logic         clock,
    input  logic         nreset,

    input  logic         word_valid_i,
    input  packed_word_t word_i,

    input  logic         ready_i,
    output logic         byte_valid_o,
    output stream_byte_t byte_o
);

    packed_word_t mem_q [FIFO_DEPTH];

    // the depth is a power of two so the pointers wrap on their own
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_PTR_WIDTH:0]   count_q;
    logic [BYTE_IDX_WIDTH-1:0] byte_idx_q;

    packed_word_t head_shifted;
    logic         full;
    logic         pop;
    logic         retire;
    logic         push;

    assign full = count_q == (FIFO_PTR_WIDTH+1)'(FIFO_DEPTH);
    assign byte_valid_o = count_q != '0;
    assign pop = byte_valid_o && ready_i;

    // the head word leaves with its last byte
    assign retire = pop && (byte_idx_q == BYTE_IDX_WIDTH'(BYTES_PER_WORD - 1));

    // a word may enter a full buffer in the cycle the head word leaves
    assign push = word_valid_i && (!full || retire);

    ////////////////////////////////////////////////////////////////////////////
    // byte selection
    always_comb begin
        head_shifted = mem_q[rd_ptr_q] << (BYTE_WIDTH * byte_idx_q);
    end

    assign byte_o = head_shifted[WORD_WIDTH-1 -: BYTE_WIDTH];

    ////////////////////////////////////////////////////////////////////////////
    // storage and pointers
    always_ff @(posedge clock) begin
        if (push) begin
            mem_q[wr_ptr_q] <= word_i;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
            byte_idx_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end

            if (pop) begin
                byte_idx_q <= byte_idx_q + 1'b1;
            end

            if (retire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end

            case ({push, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // the source rate limit has to keep the packer from outrunning the stuffer
    a_no_overflow: assert property (
        @(posedge clock) disable iff (nreset)
        word_valid_i |-> (!full || retire)
    );

endmodule

// ==== verilog/frame_flush_control.sv ====
////////////////////////////////////////////////////////////////////////////
// end of frame flush sequencer
// pads the last partial word with one bits, clears the packer, and keeps
// the frame-active flag up until the output pipeline has drained
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module frame_flush_control
    import jpeg_backend_pkg::*;
(
    input  logic      clock,
    input  logic      nreset,

    input  logic      frame_done_i,
    input  logic      codeword_valid_i,
    input  codeword_t codeword_i,
    input  code_len_t codeword_len_i,
    input  logic      word_valid_i,

    output logic      pack_valid_o,
    output codeword_t pack_data_o,
    output code_len_t pack_len_o,
    output logic      pack_clear_o,
    output logic      frame_active_o
);

    flush_state_t state_q;
    flush_state_t state_d;
    drain_count_t drain_count_q;

    ////////////////////////////////////////////////////////////////////////////
    // flush FSM and packer input mux
    always_comb begin
        state_d = state_q;
        pack_valid_o = codeword_valid_i;
        pack_data_o = codeword_i;
        pack_len_o = codeword_len_i;
        pack_clear_o = 1'b0;

        case (state_q)
            FLUSH_IDLE: begin
                if (frame_done_i) begin
                    state_d = FLUSH_PAD;
                end
            end

            FLUSH_PAD: begin
                // a full word of ones always pushes the partial word out
                pack_valid_o = 1'b1;
                pack_data_o = '1;
                pack_len_o = code_len_t'(WORD_WIDTH);
                state_d = FLUSH_CLEAR;
            end

            FLUSH_CLEAR: begin
                // drops the padding overflow and any late codewords
                pack_valid_o = 1'b0;
                pack_clear_o = 1'b1;
                if (!frame_done_i) begin
                    state_d = FLUSH_IDLE;
                end
            end

            default: begin
                state_d = FLUSH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q <= FLUSH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // drain timer and frame-active flag
    always_ff @(posedge clock) begin
        if (nreset) begin
            drain_count_q <= '0;
            frame_active_o <= 1'b0;
        end else begin
            if (!frame_done_i) begin
                drain_count_q <= '0;
            end else if (drain_count_q != drain_count_t'(DRAIN_CYCLES)) begin
                drain_count_q <= drain_count_q + drain_count_t'(1);
            end

            // a new word wins over the end of the drain period
            if (word_valid_i) begin
                frame_active_o <= 1'b1;
            end else if (drain_count_q == drain_count_t'(DRAIN_CYCLES)) begin
                frame_active_o <= 1'b0;
            end
        end
    end

    // only one padding word may be injected per frame and the packer always
    // turns it into a complete word on the next edge
    a_pad_single_cycle: assert property (
        @(posedge clock) disable iff (nreset)
        (state_q == FLUSH_PAD) |=> (state_q != FLUSH_PAD) && word_valid_i
    );

endmodule

// ==== verilog/bit_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// bit packer
// appends variable length codewords MSB first into an accumulator and
// emits a 32-bit word each time the accumulator fills, carrying the
// overflow bits into the next word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bit_packer
    import jpeg_backend_pkg::*;
(
    input  logic         clock,
    input  logic         nreset,

    input  logic         valid_i,
    input  codeword_t    data_i,
    input  code_len_t    len_i,
    input  logic         clear_i,

    output logic         word_valid_o,
    output packed_word_t word_o
);

    // bits already collected, left aligned, and how many of them are valid
    packed_word_t acc_q;
    code_len_t    fill_q;

    // the accumulator followed by one word of space for overflow
    logic [2*WORD_WIDTH-1:0] len_mask;
    logic [2*WORD_WIDTH-1:0] incoming;
    logic [2*WORD_WIDTH-1:0] merged;
    logic [LEN_WIDTH:0]      mask_shift;
    logic [LEN_WIDTH:0]      place_shift;
    logic [LEN_WIDTH:0]      new_fill;
    logic                    word_full;

    ////////////////////////////////////////////////////////////////////////////
    // alignment of the incoming codeword
    always_comb begin
        // anything above len in the codeword is dropped
        mask_shift = (LEN_WIDTH+1)'(WORD_WIDTH) - {1'b0, len_i};
        len_mask = {{WORD_WIDTH{1'b0}}, {WORD_WIDTH{1'b1}}} >> mask_shift;

        // the first codeword bit lands right below the last held bit
        place_shift = (LEN_WIDTH+1)'(2 * WORD_WIDTH) - {1'b0, fill_q} - {1'b0, len_i};
        incoming = ({{WORD_WIDTH{1'b0}}, data_i} & len_mask) << place_shift;

        merged = {acc_q, {WORD_WIDTH{1'b0}}} | incoming;
        new_fill = {1'b0, fill_q} + {1'b0, len_i};
        word_full = new_fill >= (LEN_WIDTH+1)'(WORD_WIDTH);
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulator and word output
    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q <= '0;
            fill_q <= '0;
            word_valid_o <= 1'b0;
        end else if (clear_i) begin
            // the bits below fill must be zero for the merge to work
            acc_q <= '0;
            fill_q <= '0;
            word_valid_o <= 1'b0;
        end else if (valid_i) begin
            if (word_full) begin
                acc_q <= merged[WORD_WIDTH-1:0];
                fill_q <= LEN_WIDTH'(new_fill - (LEN_WIDTH+1)'(WORD_WIDTH));
                word_valid_o <= 1'b1;
            end else begin
                acc_q <= merged[2*WORD_WIDTH-1:WORD_WIDTH];
                fill_q <= LEN_WIDTH'(new_fill);
                word_valid_o <= 1'b0;
            end
        end else begin
            word_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!clear_i && valid_i && word_full) begin
            word_o <= merged[2*WORD_WIDTH-1:WORD_WIDTH];
        end
    end

    // the flush sequencer and the encoder both have to keep lengths in range
    // or the placement shift wraps
    a_len_in_range: assert property (
        @(posedge clock) disable iff (nreset)
        valid_i |-> (len_i >= code_len_t'(1)) && (len_i <= code_len_t'(WORD_WIDTH))
    );

endmodule

// ==== verilog/jpeg_backend_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// jpeg output back end definitions
// stream widths, sizing constants and the flush sequencer states shared
// by the bit packer, the byte FIFO, the byte stuffer and the top level
////////////////////////////////////////////////////////////////////////////

package jpeg_backend_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizing
    localparam int WORD_WIDTH = 32;
    localparam int LEN_WIDTH  = 6;
    localparam int BYTE_WIDTH = 8;

    // an upper bound on how long data can live in the pipeline after the
    // encoder has finished the frame
    localparam int DRAIN_CYCLES = 256;

    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    localparam int BYTES_PER_WORD = WORD_WIDTH / BYTE_WIDTH;
    localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD);

    ////////////////////////////////////////////////////////////////////////////
    // types

    // codewords are right-aligned, only the low len bits carry data
    typedef logic [WORD_WIDTH-1:0] codeword_t;
    typedef logic [LEN_WIDTH-1:0]  code_len_t;
    typedef logic [WORD_WIDTH-1:0] packed_word_t;
    typedef logic [BYTE_WIDTH-1:0] stream_byte_t;

    // one bit wider than needed for the count itself so that it can sit at
    // DRAIN_CYCLES
    typedef logic [8:0] drain_count_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE,
        FLUSH_PAD,
        FLUSH_CLEAR
    } flush_state_t;

endpackage
